//--- sources.f
hdl/uart_pkg.sv
hdl/byte_fifo.sv
hdl/tx_feeder.sv
hdl/rx_drain.sv
hdl/bus_arbiter.sv
hdl/uart.sv
hdl/uart_subsys.sv
verif/uart_subsys_checker.sv
verif/uart_subsys_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the UART subsystem simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f sources.f --top-module uart_subsys_tb -o sim_uart_subsys
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit $status
fi

./obj_dir/sim_uart_subsys
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

exit 0

//--- verif/uart_subsys_tb.sv
`timescale 1ns/1ps

module uart_subsys_tb;
   import uart_pkg::*;

   localparam int n_tbl    = 10;
   localparam int n_single = n_tbl - fifo_depth - 1;  // the last entries form one burst
   localparam int bit_cyc  = divider + 1;
   localparam int limit    = n_tbl * 200 + 500;

   logic              clk;
   logic              rst_n;
   logic              tx_push;
   logic [data_w-1:0] tx_din;
   logic              tx_full;
   logic [data_w-1:0] rx_byte;
   logic              rx_strobe;
   logic              tx_line;
   logic              rx_line;
   logic              loop_en;
   logic              rx_drive;
   int                seed = 99;
   int                cycles = 0;
   logic [data_w-1:0] tbl_byte [n_tbl];
   logic              tbl_drv [n_tbl];           // set for a frame sent by the testbench
   logic [data_w-1:0] exp_q [$];
   logic [data_w-1:0] got_q [$];

   assign rx_line = loop_en ? tx_line : rx_drive;  // serial loopback unless broken

   uart_subsys uart_subsys_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .tx_push   (tx_push),
      .tx_din    (tx_din),
      .tx_full   (tx_full),
      .rx_byte   (rx_byte),
      .rx_strobe (rx_strobe),
      .tx        (tx_line),
      .rx        (rx_line)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         fail_run($sformatf("timeout: the test did not finish within %0d cycles", limit));
      end
   end

   always @(negedge clk) begin
      if (rst_n && rx_strobe) begin
         got_q.push_back(rx_byte);
      end
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "test stopped");
   endtask

   task automatic compare_byte(input string name, input logic [data_w-1:0] got,
                               input logic [data_w-1:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
      end
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         fail_run($sformatf("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #10;
   endtask

   task automatic push_byte(input logic [data_w-1:0] b);
      tx_push = 1'b1;
      tx_din  = b;
      next_cycle();
      tx_push = 1'b0;
   endtask

   task automatic wait_tx_start();
      @(negedge clk);
      while (tx_line !== 1'b0) @(negedge clk);
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // serial frames, start bit first and data LSB first
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic check_tx_frame(input logic [data_w-1:0] b);
      logic exp_bit;
      wait_tx_start();
      repeat (bit_cyc / 2 - 1) @(negedge clk);    // move to the middle of the start bit
      for (int i = 0; i < frame_bits; i++) begin
         if (i == 0) begin
            exp_bit = 1'b0;                       // start bit
         end else if (i == frame_bits - 1) begin
            exp_bit = 1'b1;                       // stop bit
         end else begin
            exp_bit = b[i-1];
         end
         compare_bit("tx", tx_line, exp_bit);
         repeat (bit_cyc) @(negedge clk);
      end
   endtask

   task automatic send_frame(input logic [data_w-1:0] b);
      logic [frame_bits-1:0] frame;
      frame   = {1'b1, b, 1'b0};
      loop_en = 1'b0;
      for (int i = 0; i < frame_bits; i++) begin
         rx_drive = frame[i];
         repeat (bit_cyc) next_cycle();
      end
      loop_en = 1'b1;
   endtask

   task automatic collect_rx();
      logic [data_w-1:0] got;
      while (got_q.size() < exp_q.size()) @(negedge clk);
      while (exp_q.size() > 0) begin
         got = got_q.pop_front();
         compare_byte("rx_byte", got, exp_q.pop_front());
      end
      next_cycle();
   endtask

   initial begin
      rst_n    = 1'b0;
      tx_push  = 1'b0;
      tx_din   = '0;
      loop_en  = 1'b1;
      rx_drive = 1'b1;
      tbl_byte = '{8'h55, 8'ha3, 8'h00, 8'h00, 8'hff, 8'h01, 8'h00, 8'h80, 8'h00, 8'h3c};
      tbl_drv  = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      tbl_byte[2] = data_w'($random(seed));
      tbl_byte[3] = data_w'($random(seed));
      tbl_byte[6] = data_w'($random(seed));
      tbl_byte[8] = data_w'($random(seed));
      repeat (8) @(posedge clk);
      #10 rst_n = 1'b1;
      @(negedge clk);
      compare_bit("tx", tx_line, 1'b1);
      compare_bit("rx_strobe", rx_strobe, 1'b0);
      compare_bit("tx_full", tx_full, 1'b0);
      next_cycle();
      for (int i = 0; i < n_single; i++) begin
         exp_q.push_back(tbl_byte[i]);
         if (tbl_drv[i]) begin
            send_frame(tbl_byte[i]);
         end else begin
            push_byte(tbl_byte[i]);
            check_tx_frame(tbl_byte[i]);
         end
         collect_rx();
      end
      // the rest of the queue fills up while the first byte is on the line
      exp_q.push_back(tbl_byte[n_single]);
      push_byte(tbl_byte[n_single]);
      wait_tx_start();
      next_cycle();
      for (int i = n_single + 1; i < n_tbl; i++) begin
         exp_q.push_back(tbl_byte[i]);
         tx_push = 1'b1;
         tx_din  = tbl_byte[i];
         next_cycle();
      end
      tx_push = 1'b0;
      @(negedge clk);
      compare_bit("tx_full", tx_full, 1'b1);
      collect_rx();
      repeat (2 * frame_bits * bit_cyc) next_cycle();  // room for a stray byte to show up
      if (got_q.size() != 0) begin
         fail_run("an extra byte came out on rx_byte");
      end else begin
         $display("STATUS: PASS");
         $finish;
      end
   end

endmodule

//--- verif/uart_subsys_checker.sv
`timescale 1ns/1ps

module uart_subsys_checker (
   input logic                        clk,
   input logic                        rst_n,
   input logic                        ren,
   input logic                        rd_valid,
   input logic                        wen,
   input logic                        tx,
   input logic [uart_pkg::data_w-1:0] status
);
   import uart_pkg::*;

   // each read is answered in the next cycle and rd_valid never comes on its own
   a_rd_valid: assert property (@(posedge clk) disable iff (!rst_n)
      $past(rst_n) |-> (rd_valid == $past(ren)))
      else $error("rd_valid does not follow ren by one cycle");

   a_tx_idle: assert property (@(posedge clk) disable iff (!rst_n)
      !status[tx_busy_bit] |-> tx)
      else $error("tx is low while the transmitter is idle");

   a_one_access: assert property (@(posedge clk) disable iff (!rst_n)
      !(wen && ren))
      else $error("wen and ren are high in the same cycle");

endmodule

bind uart uart_subsys_checker checker_inst (
   .clk      (clk),
   .rst_n    (rst_n),
   .ren      (ren),
   .rd_valid (rd_valid),
   .wen      (wen),
   .tx       (tx),
   .status   (status)
);

//--- hdl/uart_subsys.sv
`timescale 1ns/1ps

module uart_subsys (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        tx_push,
   input  logic [uart_pkg::data_w-1:0] tx_din,
   output logic                        tx_full,
   output logic [uart_pkg::data_w-1:0] rx_byte,
   output logic                        rx_strobe,
   output logic                        tx,
   input  logic                        rx
);
   import uart_pkg::*;

   // master 0 is the feeder, master 1 the drain
   logic              m0_req,   m1_req;
   logic [addr_w-1:0] m0_addr,  m1_addr;
   logic              m0_wen,   m1_wen;
   logic [data_w-1:0] m0_wdata, m1_wdata;
   logic              m0_ren,   m1_ren;
   logic              m0_gnt,   m1_gnt;
   logic [data_w-1:0] m0_rdata, m1_rdata;
   logic              m0_rd_valid, m1_rd_valid;

   logic [addr_w-1:0] bus_addr;
   logic              bus_wen;
   logic [data_w-1:0] bus_wdata;
   logic              bus_ren;
   logic [data_w-1:0] bus_rdata;
   logic              bus_rd_valid;

   tx_feeder #(.depth(fifo_depth)) tx_feeder_inst (
      .clk (clk), .rst_n (rst_n), .push (tx_push), .din (tx_din), .full (tx_full),
      .req (m0_req), .addr (m0_addr), .wen (m0_wen), .wdata (m0_wdata), .ren (m0_ren),
      .gnt (m0_gnt), .rdata (m0_rdata), .rd_valid (m0_rd_valid)
   );

   rx_drain rx_drain_inst (
      .clk (clk), .rst_n (rst_n), .rx_byte (rx_byte), .rx_strobe (rx_strobe),
      .req (m1_req), .addr (m1_addr), .wen (m1_wen), .wdata (m1_wdata), .ren (m1_ren),
      .gnt (m1_gnt), .rdata (m1_rdata), .rd_valid (m1_rd_valid)
   );

   bus_arbiter bus_arbiter_inst (
      .clk (clk), .rst_n (rst_n),
      .m0_req (m0_req), .m0_addr (m0_addr), .m0_wen (m0_wen), .m0_wdata (m0_wdata),
      .m0_ren (m0_ren), .m0_gnt (m0_gnt), .m0_rdata (m0_rdata), .m0_rd_valid (m0_rd_valid),
      .m1_req (m1_req), .m1_addr (m1_addr), .m1_wen (m1_wen), .m1_wdata (m1_wdata),
      .m1_ren (m1_ren), .m1_gnt (m1_gnt), .m1_rdata (m1_rdata), .m1_rd_valid (m1_rd_valid),
      .addr (bus_addr), .wen (bus_wen), .wdata (bus_wdata), .ren (bus_ren),
      .rdata (bus_rdata), .rd_valid (bus_rd_valid)
   );

   uart uart_inst (
      .clk (clk), .rst_n (rst_n), .addr (bus_addr), .ren (bus_ren),
      .rdata (bus_rdata), .rd_valid (bus_rd_valid), .wen (bus_wen), .wdata (bus_wdata),
      .tx (tx), .rx (rx)
   );

endmodule

//--- hdl/uart.sv
`timescale 1ns/1ps

module uart (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic [uart_pkg::addr_w-1:0] addr,
   input  logic                        ren,
   output logic [uart_pkg::data_w-1:0] rdata,
   output logic                        rd_valid,
   input  logic                        wen,
   input  logic [uart_pkg::data_w-1:0] wdata,
   output logic                        tx,
   input  logic                        rx
);
   import uart_pkg::*;

   typedef enum logic {idle_s, busy_s} state_t;

   state_t                tx_state;
   state_t                rx_state;
   logic [bit_cnt_w-1:0]  tx_bit;
   logic [bit_cnt_w-1:0]  rx_bit;
   logic [baud_cnt_w-1:0] tx_cnt;
   logic [baud_cnt_w-1:0] rx_cnt;
   logic [frame_bits-1:0] tx_shift;
   logic [data_w:0]       rx_shift;
   logic [data_w-1:0]     rx_data;
   logic                  rx_avail;
   logic                  rx_clear;
   logic [data_w-1:0]     status;
   logic                  tx_load;
   logic                  tx_tick;
   logic                  rx_tick;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // register decode
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb begin
      status               = '0;
      status[tx_busy_bit]  = (tx_state == busy_s);
      status[rx_avail_bit] = rx_avail;
   end

   assign tx_load = wen && (addr == reg_data) && (tx_state == idle_s);  // writes while busy are lost

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_valid <= 1'b0;
         rx_clear <= 1'b0;
      end else begin
         rd_valid <= ren;                          // every read answers one cycle later
         rx_clear <= ren && (addr == reg_data);
      end
   end

   always_ff @(posedge clk) begin
      if (ren) begin
         case (addr)
            reg_data:   rdata <= rx_data;
            reg_status: rdata <= status;
            default:    rdata <= '0;
         endcase
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // receiver
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign rx_tick = (rx_cnt == '0);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_state <= idle_s;
         rx_cnt   <= '0;
         rx_bit   <= '0;
         rx_avail <= 1'b0;
      end else begin
         if (rx_clear) begin
            rx_avail <= 1'b0;
         end
         case (rx_state)
            idle_s: begin
               if (!rx) begin
                  rx_cnt   <= baud_cnt_w'(divider >> 1);  // half a bit to reach mid-bit
                  rx_bit   <= bit_cnt_w'(frame_bits - 1);
                  rx_state <= busy_s;
               end
            end
            busy_s: begin
               if (rx_tick) begin
                  rx_cnt <= baud_cnt_w'(divider);
                  rx_bit <= rx_bit - 1'b1;
                  if (rx_bit == '0) begin
                     rx_avail <= 1'b1;                 // a new byte wins over a clear
                     rx_state <= idle_s;
                  end
               end else begin
                  rx_cnt <= rx_cnt - 1'b1;
               end
            end
            default: rx_state <= idle_s;
         endcase
      end
   end

   // start bit ends up in bit 0 and is dropped when the stop bit is sampled
   always_ff @(posedge clk) begin
      if ((rx_state == busy_s) && rx_tick) begin
         if (rx_bit == '0) begin
            rx_data <= rx_shift[data_w:1];
         end else begin
            rx_shift <= {rx, rx_shift[data_w:1]};
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // transmitter
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign tx_tick = (tx_cnt == '0);
   assign tx      = (tx_state == busy_s) ? tx_shift[0] : 1'b1;  // line idles high

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx_state <= idle_s;
         tx_cnt   <= '0;
         tx_bit   <= '0;
      end else begin
         case (tx_state)
            idle_s: begin
               if (tx_load) begin
                  tx_cnt   <= baud_cnt_w'(divider);
                  tx_bit   <= bit_cnt_w'(frame_bits - 1);
                  tx_state <= busy_s;
               end
            end
            busy_s: begin
               if (tx_tick) begin
                  tx_cnt <= baud_cnt_w'(divider);
                  tx_bit <= tx_bit - 1'b1;
                  if (tx_bit == '0) begin
                     tx_state <= idle_s;            // stop bit done
                  end
               end else begin
                  tx_cnt <= tx_cnt - 1'b1;
               end
            end
            default: tx_state <= idle_s;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (tx_load) begin
         tx_shift <= {1'b1, wdata, 1'b0};
      end else if ((tx_state == busy_s) && tx_tick) begin
         tx_shift <= tx_shift >> 1;
      end
   end

endmodule

//--- hdl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        m0_req,
   input  logic [uart_pkg::addr_w-1:0] m0_addr,
   input  logic                        m0_wen,
   input  logic [uart_pkg::data_w-1:0] m0_wdata,
   input  logic                        m0_ren,
   output logic                        m0_gnt,
   output logic [uart_pkg::data_w-1:0] m0_rdata,
   output logic                        m0_rd_valid,
   input  logic                        m1_req,
   input  logic [uart_pkg::addr_w-1:0] m1_addr,
   input  logic                        m1_wen,
   input  logic [uart_pkg::data_w-1:0] m1_wdata,
   input  logic                        m1_ren,
   output logic                        m1_gnt,
   output logic [uart_pkg::data_w-1:0] m1_rdata,
   output logic                        m1_rd_valid,
   output logic [uart_pkg::addr_w-1:0] addr,
   output logic                        wen,
   output logic [uart_pkg::data_w-1:0] wdata,
   output logic                        ren,
   input  logic [uart_pkg::data_w-1:0] rdata,
   input  logic                        rd_valid
);

   logic last_m1;                              // master 1 had the most recent grant
   logic pend;                                 // a read is waiting for its answer
   logic pend_m1;                              // owner of that read

   // on a tie the master granted last time waits
   assign m0_gnt = !pend && m0_req && (!m1_req || last_m1);
   assign m1_gnt = !pend && m1_req && (!m0_req || !last_m1);

   assign addr  = m1_gnt ? m1_addr : m0_addr;
   assign wdata = m1_gnt ? m1_wdata : m0_wdata;
   assign wen   = (m0_gnt && m0_wen) || (m1_gnt && m1_wen);
   assign ren   = (m0_gnt && m0_ren) || (m1_gnt && m1_ren);

   assign m0_rdata    = rdata;
   assign m1_rdata    = rdata;
   assign m0_rd_valid = rd_valid && pend && !pend_m1;
   assign m1_rd_valid = rd_valid && pend && pend_m1;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         last_m1 <= 1'b1;                      // master 0 goes first
         pend    <= 1'b0;
         pend_m1 <= 1'b0;
      end else begin
         if (m0_gnt || m1_gnt) begin
            last_m1 <= m1_gnt;
         end
         if (ren) begin
            pend    <= 1'b1;
            pend_m1 <= m1_gnt;
         end else if (rd_valid) begin
            pend <= 1'b0;
         end
      end
   end

endmodule

//--- hdl/rx_drain.sv
`timescale 1ns/1ps

module rx_drain (
   input  logic                        clk,
   input  logic                        rst_n,
   output logic [uart_pkg::data_w-1:0] rx_byte,
   output logic                        rx_strobe,
   output logic                        req,
   output logic [uart_pkg::addr_w-1:0] addr,
   output logic                        wen,
   output logic [uart_pkg::data_w-1:0] wdata,
   output logic                        ren,
   input  logic                        gnt,
   input  logic [uart_pkg::data_w-1:0] rdata,
   input  logic                        rd_valid
);
   import uart_pkg::*;

   typedef enum logic [2:0] {poll_s, stat_s, read_s, data_s, gap_s} state_t;

   state_t state;

   assign req   = (state == poll_s) || (state == read_s);
   assign ren   = req;                          // this master only reads
   assign wen   = 1'b0;
   assign wdata = '0;
   assign addr  = (state == read_s) ? reg_data : reg_status;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= poll_s;
         rx_strobe <= 1'b0;
      end else begin
         rx_strobe <= (state == data_s) && rd_valid;
         case (state)
            poll_s: if (gnt) state <= stat_s;
            stat_s: begin
               if (rd_valid) begin
                  state <= rdata[rx_avail_bit] ? read_s : poll_s;
               end
            end
            read_s: if (gnt) state <= data_s;
            data_s: if (rd_valid) state <= gap_s;
            gap_s:  state <= poll_s;               // lets the avail flag clear
            default: state <= poll_s;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((state == data_s) && rd_valid) begin
         rx_byte <= rdata;
      end
   end

endmodule

//--- hdl/tx_feeder.sv
`timescale 1ns/1ps

module tx_feeder #(
   parameter int depth = uart_pkg::fifo_depth
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        push,
   input  logic [uart_pkg::data_w-1:0] din,
   output logic                        full,
   output logic                        req,
   output logic [uart_pkg::addr_w-1:0] addr,
   output logic                        wen,
   output logic [uart_pkg::data_w-1:0] wdata,
   output logic                        ren,
   input  logic                        gnt,
   input  logic [uart_pkg::data_w-1:0] rdata,
   input  logic                        rd_valid
);
   import uart_pkg::*;

   typedef enum logic [2:0] {idle_s, poll_s, stat_s, write_s, hold_s} state_t;

   state_t            state;
   logic              q_pop;
   logic              q_empty;
   logic [data_w-1:0] q_dout;

   byte_fifo #(.depth(depth)) queue_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .push  (push),
      .din   (din),
      .pop   (q_pop),
      .dout  (q_dout),
      .full  (full),
      .empty (q_empty)
   );

   // access is held until granted
   assign req   = (state == poll_s) || (state == write_s);
   assign ren   = (state == poll_s);
   assign wen   = (state == write_s);
   assign addr  = (state == write_s) ? reg_data : reg_status;
   assign wdata = q_dout;                      // head stays put until the pop
   assign q_pop = (state == write_s) && gnt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= idle_s;
      end else begin
         case (state)
            idle_s:  if (!q_empty) state <= poll_s;
            poll_s:  if (gnt) state <= stat_s;
            stat_s: begin
               if (rd_valid) begin
                  state <= rdata[tx_busy_bit] ? poll_s : write_s;
               end
            end
            write_s: if (gnt) state <= hold_s;
            hold_s:  state <= idle_s;            // busy shows one cycle after the write
            default: state <= idle_s;
         endcase
      end
   end

endmodule

//--- hdl/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo #(
   parameter int depth = uart_pkg::fifo_depth
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        push,
   input  logic [uart_pkg::data_w-1:0] din,
   input  logic                        pop,
   output logic [uart_pkg::data_w-1:0] dout,
   output logic                        full,
   output logic                        empty
);
   import uart_pkg::*;

   localparam int ptr_w  = (depth > 1) ? $clog2(depth) : 1;
   localparam int fill_w = $clog2(depth + 1);

   logic [data_w-1:0] mem [depth];
   logic [ptr_w-1:0]  wr_ptr;
   logic [ptr_w-1:0]  rd_ptr;
   logic [fill_w-1:0] count;
   logic [fill_w-1:0] count_next;
   logic              do_push;
   logic              do_pop;

   assign do_push    = push && !full;        // pushes into a full queue are dropped
   assign do_pop     = pop && !empty;
   assign count_next = count + fill_w'(do_push) - fill_w'(do_pop);
   assign dout       = mem[rd_ptr];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         full   <= 1'b0;
         empty  <= 1'b1;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count_next;
         full  <= (count_next == fill_w'(depth));
         empty <= (count_next == '0);
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= din;
      end
   end

endmodule

//--- hdl/uart_pkg.sv
package uart_pkg;

   localparam int addr_w = 5;                 // register address width
   localparam int data_w = 8;                 // bus word and serial character width

   // register map
   localparam logic [addr_w-1:0] reg_data   = 5'd0;  // write starts tx, read pops rx
   localparam logic [addr_w-1:0] reg_status = 5'd4;

   localparam int tx_busy_bit  = 0;           // set while a frame is going out
   localparam int rx_avail_bit = 1;           // set while a received byte is unread

   // serial timing
   localparam int divider    = 7;             // bit period is divider plus one cycles
   localparam int frame_bits = 10;            // start, eight data bits, stop
   localparam int baud_cnt_w = $clog2(divider + 1);
   localparam int bit_cnt_w  = $clog2(frame_bits);

   localparam int fifo_depth = 4;             // default byte queue depth

endpackage
